/* hw/minerPkg.sv */
package minerPkg;

    // Named Bitcoin fields, first wire byte in the top bits
    typedef struct packed {
        logic [31:0]  version;
        logic [255:0] prevHash;
        logic [255:0] merkleRoot;
        logic [31:0]  timeStamp;
        logic [31:0]  targetBits;
        // Nonce bytes exactly as received
        logic [31:0]  nonceField;
    } headerFields_t;

    // Same 80 bytes seen as big-endian SHA-256 message words
    typedef union packed {
        headerFields_t     fields;
        logic [0:19][31:0] words;
    } blockHeader_u;

    typedef struct packed {
        blockHeader_u header;
        logic         run;
    } miningJob_t;

    // Per-try report of one lane
    typedef struct packed {
        logic        done;
        logic        found;
        logic [31:0] nonce;
    } laneResult_t;

    // Round constants
    localparam logic [0:63][31:0] sha256K = {
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Initial hash value H0..H7
    localparam logic [0:7][31:0] sha256Init = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

endpackage

/* hw/headerLoader.sv */
`timescale 1ns/100ps

module headerLoader (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   rxValid,
    input  logic [7:0]             rxByte,
    output minerPkg::blockHeader_u header,
    output logic                   headerReady,
    output logic [31:0]            byteCount
);

    // Slot of the next byte, 0 to 79
    logic [6:0]   byteIndex;
    // Header in progress, oldest byte on top
    logic [639:0] shiftBytes;
    logic         lastByte;

    assign lastByte = rxValid && (byteIndex == 7'd79);

    always_ff @(posedge clock) begin
        if (rst) begin
            byteIndex   <= '0;
            byteCount   <= '0;
            headerReady <= 1'b0;
        end else begin
            headerReady <= lastByte;
            if (rxValid) begin
                // Free-running total of every byte seen
                byteCount <= byteCount + 32'd1;
                byteIndex <= lastByte ? 7'd0 : byteIndex + 7'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rxValid) begin
            shiftBytes <= {shiftBytes[631:0], rxByte};
        end
        // Published copy only changes on a full header
        if (lastByte) begin
            header <= {shiftBytes[631:0], rxByte};
        end
    end

endmodule

/* hw/nonceDispatch.sv */
`timescale 1ns/100ps

module nonceDispatch #(
    parameter int numLanes = 4
) (
    input  logic                   clock,
    input  logic                   rst,
    input  minerPkg::blockHeader_u header,
    input  logic                   headerReady,
    input  logic                   stopPulse,
    output minerPkg::miningJob_t   job,
    output logic [numLanes-1:0]    laneStart,
    output logic                   busy
);
    import minerPkg::*;

    blockHeader_u jobHeader;
    logic         runBit;

    always_ff @(posedge clock) begin
        if (rst) begin
            runBit    <= 1'b0;
            busy      <= 1'b0;
            laneStart <= '0;
        end else begin
            // One start flop per lane, all fire together
            laneStart <= {numLanes{headerReady}};
            if (headerReady) begin
                runBit <= 1'b1;
                busy   <= 1'b1;
            end else if (stopPulse) begin
                // Halt seen by every lane in the same cycle
                runBit <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (headerReady) begin
            jobHeader <= header;
        end
    end

    always_comb begin
        job.header = jobHeader;
        job.run    = runBit;
    end

endmodule

/* hw/sha256Compress.sv */
`timescale 1ns/100ps

module sha256Compress (
    input  logic         clock,
    input  logic         rst,
    input  logic         start,
    input  logic [255:0] chainIn,
    input  logic [511:0] block,
    output logic [255:0] digest,
    output logic         done
);
    import minerPkg::*;

    // Rolling schedule, sched[0] is W for this round
    logic [0:15][31:0] sched;
    // Working variables
    logic [31:0]       a, b, c, d, e, f, g, h;
    logic [5:0]        round;
    logic              active;
    logic [31:0]       t1;
    logic [31:0]       t2;
    logic [31:0]       nextW;
    logic [0:7][31:0]  chainWords;
    logic [0:7][31:0]  newWork;
    logic [0:7][31:0]  sumWords;

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    always_comb begin
        t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25))
               + ((e & f) ^ (~e & g)) + sha256K[round] + sched[0];
        t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22))
           + ((a & b) ^ (a & c) ^ (b & c));
        // W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
        nextW = (rotr(sched[14], 17) ^ rotr(sched[14], 19) ^ (sched[14] >> 10))
              + sched[9]
              + (rotr(sched[1], 7) ^ rotr(sched[1], 18) ^ (sched[1] >> 3))
              + sched[0];
        newWork    = {t1 + t2, a, b, c, d + t1, e, f, g};
        chainWords = chainIn;
        // Feed-forward add of the chaining value
        for (int i = 0; i < 8; i++) begin
            sumWords[i] = chainWords[i] + newWork[i];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            active <= 1'b0;
            done   <= 1'b0;
            round  <= '0;
        end else begin
            done <= 1'b0;
            // A new start overrides a run in flight
            if (start) begin
                active <= 1'b1;
                round  <= '0;
            end else if (active) begin
                round <= round + 6'd1;
                if (round == 6'd63) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            // Load cycle
            {a, b, c, d, e, f, g, h} <= chainIn;
            sched <= block;
        end else if (active) begin
            {a, b, c, d, e, f, g, h} <= newWork;
            sched <= {sched[1:15], nextW};
            if (round == 6'd63) begin
                digest <= sumWords;
            end
        end
    end

endmodule

/* hw/hashLane.sv */
`timescale 1ns/100ps

module hashLane #(
    parameter int numLanes       = 4,
    parameter int targetZeroBits = 32,
    parameter int laneIndex      = 0
) (
    input  logic                  clock,
    input  logic                  rst,
    input  minerPkg::miningJob_t  job,
    input  logic                  laneStart,
    output minerPkg::laneResult_t result,
    output logic [31:0]           digestHead
);
    import minerPkg::*;

    typedef enum logic [2:0] {IDLE, FIRST, SECOND, THIRD, REPORT} laneState_e;

    // Low digest bits that must be zero
    localparam logic [63:0] zeroMask = {64{1'b1}} >> (64 - targetZeroBits);

    laneState_e   state;
    logic         startPulse;
    // Nonce as a little-endian integer
    logic [31:0]  nonceInt;
    logic [255:0] midstate;
    logic [255:0] chain;
    logic [511:0] block;
    logic [511:0] block1;
    logic [511:0] block2;
    logic [511:0] block3;
    logic         compStart;
    logic         compDone;
    logic         stageDone;
    logic         reportNow;
    logic [255:0] compDigest;
    logic         doneReg;
    logic         foundReg;
    logic [31:0]  nonceOut;

    function automatic logic [31:0] byteSwap(input logic [31:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction

    assign block1 = job.header.words[0:15];
    // Header tail, 80-byte message padding
    assign block2 = {job.header.words[16:18], byteSwap(nonceInt),
                     32'h80000000, 288'd0, 64'd640};
    // Second pass over the 32-byte first digest
    assign block3 = {compDigest, 32'h80000000, 160'd0, 64'd256};

    // A done that meets a restart belongs to a dropped try
    assign stageDone = compDone && !startPulse;
    assign compStart = startPulse || (stageDone && (state == FIRST || state == SECOND));
    assign reportNow = (state == THIRD) && stageDone && job.run && !laneStart;

    // Chain input must hold at load and at the last round
    always_comb begin
        chain = sha256Init;
        block = block1;
        if (state == FIRST && stageDone) begin
            chain = compDigest;
            block = block2;
        end else if (state == SECOND && !stageDone) begin
            chain = midstate;
        end else if (state == SECOND && stageDone) begin
            block = block3;
        end
    end

    sha256Compress comp0 (
        .clock  (clock),
        .rst    (rst),
        .start  (compStart),
        .chainIn(chain),
        .block  (block),
        .digest (compDigest),
        .done   (compDone)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= IDLE;
            startPulse <= 1'b0;
            doneReg    <= 1'b0;
            foundReg   <= 1'b0;
        end else begin
            startPulse <= 1'b0;
            doneReg    <= 1'b0;
            if (laneStart) begin
                state      <= FIRST;
                startPulse <= 1'b1;
            end else begin
                case (state)
                    FIRST: begin
                        if (!job.run) state <= IDLE;
                        else if (stageDone) state <= SECOND;
                    end
                    SECOND: begin
                        if (!job.run) state <= IDLE;
                        else if (stageDone) state <= THIRD;
                    end
                    THIRD: begin
                        if (!job.run) begin
                            state <= IDLE;
                        end else if (stageDone) begin
                            state    <= REPORT;
                            doneReg  <= 1'b1;
                            foundReg <= (compDigest[63:0] & zeroMask) == 64'd0;
                        end
                    end
                    REPORT: begin
                        // Gap cycle before the next try
                        if (job.run) begin
                            state      <= FIRST;
                            startPulse <= 1'b1;
                        end else begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (laneStart) begin
            nonceInt <= byteSwap(job.header.fields.nonceField) + 32'(laneIndex);
        end else if (reportNow) begin
            nonceInt <= nonceInt + 32'(numLanes);
        end
        if (state == FIRST && stageDone) begin
            midstate <= compDigest;
        end
        if (reportNow) begin
            // Back to wire byte order
            nonceOut   <= byteSwap(nonceInt);
            digestHead <= compDigest[255:224];
        end
    end

    always_comb begin
        result.done  = doneReg;
        result.found = foundReg;
        result.nonce = nonceOut;
    end

endmodule

/* hw/resultCollector.sv */
`timescale 1ns/100ps

module resultCollector #(
    parameter int numLanes = 4
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  minerPkg::laneResult_t [numLanes-1:0] results,
    input  logic [numLanes-1:0][31:0]            digestHeads,
    input  logic                                 headerReady,
    input  minerPkg::blockHeader_u               header,
    input  logic [31:0]                          byteCount,
    input  logic [1:0]                           displaySelect,
    output logic                                 found,
    output logic [31:0]                          finalNonce,
    output logic                                 stopPulse,
    output logic [31:0]                          displayValue
);

    logic        anyWin;
    logic [31:0] winNonce;
    logic [31:0] winHead;
    logic [31:0] winDigestHead;
    logic [31:0] lastCount;
    logic        byteSeen;
    logic        takeWin;

    // Priority pick, lowest lane index wins
    always_comb begin
        anyWin   = 1'b0;
        winNonce = '0;
        winHead  = '0;
        for (int i = numLanes - 1; i >= 0; i--) begin
            if (results[i].done && results[i].found) begin
                anyWin   = 1'b1;
                winNonce = results[i].nonce;
                winHead  = digestHeads[i];
            end
        end
    end

    // Any byte except the completing one means a new header
    assign byteSeen = (byteCount != lastCount) && !headerReady;
    assign takeWin  = anyWin && !found && !headerReady && !byteSeen;

    always_ff @(posedge clock) begin
        if (rst) begin
            found        <= 1'b0;
            finalNonce   <= '0;
            stopPulse    <= 1'b0;
            lastCount    <= '0;
            displayValue <= '0;
        end else begin
            lastCount <= byteCount;
            stopPulse <= 1'b0;
            if (headerReady) begin
                found      <= 1'b0;
                finalNonce <= '0;
            end else if (byteSeen) begin
                // Abort the search for the old header
                found     <= 1'b0;
                stopPulse <= 1'b1;
            end else if (takeWin) begin
                found      <= 1'b1;
                finalNonce <= winNonce;
                stopPulse  <= 1'b1;
            end
            case (displaySelect)
                2'd0: displayValue <= finalNonce;
                2'd1: displayValue <= header.fields.version;
                2'd2: displayValue <= byteCount;
                default: displayValue <= winDigestHead;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (takeWin) begin
            winDigestHead <= winHead;
        end
    end

endmodule

/* hw/minerTop.sv */
`timescale 1ns/100ps

module minerTop #(
    parameter int numLanes       = 4,
    parameter int targetZeroBits = 32
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        rxValid,
    input  logic [7:0]  rxByte,
    input  logic [1:0]  displaySelect,
    output logic        busy,
    output logic        found,
    output logic [31:0] finalNonce,
    output logic [31:0] displayValue
);
    import minerPkg::*;

    blockHeader_u              header;
    logic                      headerReady;
    logic [31:0]               byteCount;
    miningJob_t                job;
    logic [numLanes-1:0]       laneStart;
    logic                      stopPulse;
    laneResult_t [numLanes-1:0] laneResults;
    logic [numLanes-1:0][31:0] digestHeads;

    headerLoader loader0 (
        .clock      (clock),
        .rst        (rst),
        .rxValid    (rxValid),
        .rxByte     (rxByte),
        .header     (header),
        .headerReady(headerReady),
        .byteCount  (byteCount)
    );

    nonceDispatch #(.numLanes(numLanes)) dispatch0 (
        .clock      (clock),
        .rst        (rst),
        .header     (header),
        .headerReady(headerReady),
        .stopPulse  (stopPulse),
        .job        (job),
        .laneStart  (laneStart),
        .busy       (busy)
    );

    // Identical lanes, interleaved nonces
    for (genvar laneIdx = 0; laneIdx < numLanes; laneIdx++) begin : gLane
        hashLane #(
            .numLanes      (numLanes),
            .targetZeroBits(targetZeroBits),
            .laneIndex     (laneIdx)
        ) lane (
            .clock     (clock),
            .rst       (rst),
            .job       (job),
            .laneStart (laneStart[laneIdx]),
            .result    (laneResults[laneIdx]),
            .digestHead(digestHeads[laneIdx])
        );
    end

    resultCollector #(.numLanes(numLanes)) collector0 (
        .clock        (clock),
        .rst          (rst),
        .results      (laneResults),
        .digestHeads  (digestHeads),
        .headerReady  (headerReady),
        .header       (header),
        .byteCount    (byteCount),
        .displaySelect(displaySelect),
        .found        (found),
        .finalNonce   (finalNonce),
        .stopPulse    (stopPulse),
        .displayValue (displayValue)
    );

endmodule

/* dv/minerTb.sv */
`timescale 1ns/100ps

module minerTb;

    // Cycle limits for the polling loops
    localparam int foundLimit  = 3000;
    localparam int settleLimit = 10;

    // True nonce of block 125552 as a little-endian integer
    localparam logic [31:0] trueNonce = 32'h9546a142;
    // Same nonce as its four header bytes, first byte on top
    localparam logic [31:0] trueField = 32'h42a14695;
    // First word of that block's final digest
    localparam logic [31:0] knownHead = 32'h1dbd981f;

    // Block 125552 header in wire order, nonce left off
    localparam logic [607:0] baseHeader = {
        32'h01000000,
        256'h81cd02ab7e569e8bcd9317e2fe99f2de44d49ab2b8851ba4a308000000000000,
        256'he320b6c2fffc8d750423db8b1eb942ae710e951ed797f7affc8892b0f1fc122b,
        32'hc7f5d74d,
        32'hf2b9441a
    };

    logic        clock;
    logic        rst;
    logic        rxValid;
    logic [7:0]  rxByte;
    logic [1:0]  displaySelect;
    logic        busy;
    logic        found;
    logic [31:0] finalNonce;
    logic [31:0] displayValue;

    // Bytes of the header being sent
    logic [7:0]  hdrBytes [0:79];
    int          errorCount;
    int          checkCount;
    int          bytesSent;

    minerTop dut0 (
        .clock        (clock),
        .rst          (rst),
        .rxValid      (rxValid),
        .rxByte       (rxByte),
        .displaySelect(displaySelect),
        .busy         (busy),
        .found        (found),
        .finalNonce   (finalNonce),
        .displayValue (displayValue)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Inputs change just after the rising edge
    task automatic stepCycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic buildHeader(input logic [31:0] nonceInt);
        for (int k = 0; k < 76; k++) begin
            hdrBytes[k] = baseHeader[607 - 8 * k -: 8];
        end
        // Nonce goes out low byte first
        hdrBytes[76] = nonceInt[7:0];
        hdrBytes[77] = nonceInt[15:8];
        hdrBytes[78] = nonceInt[23:16];
        hdrBytes[79] = nonceInt[31:24];
    endtask

    task automatic sendRange(input int first, input int count);
        for (int k = first; k < first + count; k++) begin
            rxValid = 1'b1;
            rxByte  = hdrBytes[k];
            stepCycle();
            bytesSent++;
        end
        rxValid = 1'b0;
        rxByte  = 8'h00;
    endtask

    task automatic sendHeader();
        sendRange(0, 80);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s actual 0x%08h expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic waitFound(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (found !== level && cycles < limit) begin
            stepCycle();
            cycles++;
        end
        if (found !== level) begin
            errorCount++;
            $display("timeout: found did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic waitBusyLow(input int limit);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < limit) begin
            stepCycle();
            cycles++;
        end
        if (busy !== 1'b0) begin
            errorCount++;
            $display("timeout: busy stayed high for %0d cycles", limit);
        end
    endtask

    // Display path is one register deep
    task automatic readDisplay(input logic [1:0] sel);
        displaySelect = sel;
        stepCycle();
        stepCycle();
    endtask

    task automatic finishTest(input string name, input int startErrors);
        $display("%s finished with %0d errors", name, errorCount - startErrors);
    endtask

    task automatic checkResetState();
        int startErrors;
        startErrors = errorCount;
        stepCycle();
        checkValue("found", found, 32'd0);
        checkValue("busy", busy, 32'd0);
        checkValue("finalNonce", finalNonce, 32'd0);
        checkValue("displayValue", displayValue, 32'd0);
        finishTest("reset state", startErrors);
    endtask

    task automatic mineKnownBlock();
        int startErrors;
        startErrors = errorCount;
        // Start nine below the solution so lane 1 hits it on its third try
        buildHeader(trueNonce - 32'd9);
        sendHeader();
        // Job is running one cycle after headerReady
        stepCycle();
        checkValue("busy", busy, 32'd1);
        waitFound(1'b1, foundLimit);
        checkValue("found", found, 32'd1);
        checkValue("finalNonce", finalNonce, trueField);
        waitBusyLow(settleLimit);
        checkValue("busy", busy, 32'd0);
        readDisplay(2'd3);
        checkValue("displayValue", displayValue, knownHead);
        finishTest("known block", startErrors);
    endtask

    task automatic countBytes();
        int startErrors;
        startErrors = errorCount;
        // Opening bytes of the restart header
        buildHeader(trueNonce);
        sendRange(0, 5);
        waitFound(1'b0, settleLimit);
        checkValue("found", found, 32'd0);
        readDisplay(2'd2);
        checkValue("displayValue", displayValue, 32'(bytesSent));
        finishTest("byte count", startErrors);
    endtask

    task automatic selectDisplay();
        int startErrors;
        startErrors = errorCount;
        // Published header is still the mined one
        readDisplay(2'd1);
        checkValue("displayValue", displayValue,
                   {hdrBytes[0], hdrBytes[1], hdrBytes[2], hdrBytes[3]});
        // Partial header leaves the nonce in place
        readDisplay(2'd0);
        checkValue("displayValue", displayValue, trueField);
        checkValue("finalNonce", finalNonce, trueField);
        finishTest("display select", startErrors);
    endtask

    task automatic restartSearch();
        int startErrors;
        startErrors = errorCount;
        // Rest of the header begun during the byte count
        sendRange(5, 75);
        checkValue("found", found, 32'd0);
        // headerReady wipes the old result and starts the job
        stepCycle();
        checkValue("finalNonce", finalNonce, 32'd0);
        checkValue("busy", busy, 32'd1);
        waitFound(1'b1, foundLimit);
        checkValue("found", found, 32'd1);
        checkValue("finalNonce", finalNonce, trueField);
        waitBusyLow(settleLimit);
        checkValue("busy", busy, 32'd0);
        readDisplay(2'd3);
        checkValue("displayValue", displayValue, knownHead);
        readDisplay(2'd2);
        checkValue("displayValue", displayValue, 32'(bytesSent));
        finishTest("restart", startErrors);
    endtask

    initial begin
        rst           = 1'b1;
        rxValid       = 1'b0;
        rxByte        = 8'h00;
        displaySelect = 2'd2;
        errorCount    = 0;
        checkCount    = 0;
        bytesSent     = 0;
        repeat (3) @(posedge clock);
        #0.5;
        rst = 1'b0;

        checkResetState();
        mineKnownBlock();
        countBytes();
        selectDisplay();
        restartSearch();

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/minerPkg.sv
hw/headerLoader.sv
hw/nonceDispatch.sv
hw/sha256Compress.sv
hw/hashLane.sv
hw/resultCollector.sv
hw/minerTop.sv
dv/minerTb.sv
